// File: Bender.yml
package:
  name: cpu_core

sources:
  - verilog/cpu_isa_pkg.sv
  - verilog/cpu_pipe_pkg.sv
  - verilog/inst_decode.sv
  - verilog/alu_execute.sv
  - verilog/wb_result.sv
  - verilog/cpu_core_top.sv
  - target: test
    files:
      - dv/cpu_core_sva.sv
      - dv/cpu_core_tb.sv

// File: all.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/inst_decode.sv
verilog/alu_execute.sv
verilog/wb_result.sv
verilog/cpu_core_top.sv
dv/cpu_core_sva.sv
dv/cpu_core_tb.sv

// File: dv/cpu_core_sva.sv
`timescale 1ns/1ns

module cpu_core_sva (
    input logic                                clk,
    input logic                                reset,
    input logic                                i_inst_valid,
    input logic                                o_wb_valid,
    input logic [3:0]                          o_wb_rf_we,
    input logic [cpu_isa_pkg::REG_ADDR_W-1:0]  o_wb_rf_wnum
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit trace
    // ~~~~~~~~~~~~~~~~~~~~
    a_reset_quiet: assert property (@(posedge clk) reset |=> (!o_wb_valid && o_wb_rf_we == 4'h0))
        else begin
            $error("commit trace active during reset");
            fail_count++;
        end

    a_we_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (o_wb_rf_we != 4'h0) |-> o_wb_valid)
        else begin
            $error("register write strobe without a valid commit");
            fail_count++;
        end

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        (o_wb_rf_wnum == '0) |-> (o_wb_rf_we == 4'h0))
        else begin
            $error("register write strobe aimed at r0");
            fail_count++;
        end

    // Fixed three cycle latency, no stalls
    a_latency: assert property (@(posedge clk) disable iff (reset)
        i_inst_valid |-> ##3 o_wb_valid)
        else begin
            $error("issued instruction did not commit three cycles later");
            fail_count++;
        end

endmodule

bind cpu_core_top cpu_core_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .i_inst_valid (i_inst_valid),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rf_we   (o_wb_rf_we),
    .o_wb_rf_wnum (o_wb_rf_wnum)
);

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ns

module cpu_core_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int MAX_INSTS      = 150;                    // About 125 issued over all tests
    localparam int GAP_CYCLES     = 60;                     // 20 gapped issues, up to 3 idle each
    localparam int DRAIN_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + MAX_INSTS + GAP_CYCLES + 6 * DRAIN_CYCLES);

    typedef struct packed {
        int           due;                                  // Negedge count of the commit
        logic [31:0]  pc;
        logic [3:0]   we;
        logic [4:0]   wnum;
        logic [31:0]  wdata;
    } trace_t;

    logic         clk;
    logic         reset;
    logic         i_inst_valid;
    logic [31:0]  i_pc;
    logic [31:0]  i_inst;
    logic         o_wb_valid;
    logic [31:0]  o_wb_pc;
    logic [3:0]   o_wb_rf_we;
    logic [4:0]   o_wb_rf_wnum;
    logic [31:0]  o_wb_rf_wdata;

    logic [31:0]  model [32];                               // Reference register file
    trace_t       exp_q [$];
    trace_t       head;
    string        cur_test;
    integer       seed = 32'h90c9;
    logic [31:0]  next_pc;
    int           cycle;
    int           timeout_count;
    int           err_count;
    int           check_count;
    int           test_count;
    int           test_errs;

    cpu_core_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] ref_alu(input cpu_isa_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]   sh;
        logic [31:0]  r;
        sh = b[4:0];
        case (op)
            cpu_isa_pkg::ALU_ADD:  r = a + b;
            cpu_isa_pkg::ALU_SUB:  r = a + ~b + 32'd1;
            cpu_isa_pkg::ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            cpu_isa_pkg::ALU_SLTU: r = {31'b0, a < b};
            cpu_isa_pkg::ALU_AND:  r = a & b;
            cpu_isa_pkg::ALU_OR:   r = a | b;
            cpu_isa_pkg::ALU_NOR:  r = ~(a | b);
            cpu_isa_pkg::ALU_XOR:  r = a ^ b;
            cpu_isa_pkg::ALU_SLL:  r = a << sh;
            cpu_isa_pkg::ALU_SRL:  r = a >> sh;
            cpu_isa_pkg::ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:               r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     cur_test, what, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic issue(input logic [31:0] inst, input logic writes, input logic [4:0] rd,
                         input logic [31:0] value);
        trace_t t;
        @(posedge clk);
        i_inst_valid <= 1'b1;
        i_pc         <= next_pc;
        i_inst       <= inst;
        t.due   = cycle + 4;                                // Decode, execute, writeback edges
        t.pc    = next_pc;
        t.we    = writes ? 4'hf : 4'h0;
        t.wnum  = rd;
        t.wdata = value;
        exp_q.push_back(t);
        if (writes) begin
            model[rd] = value;
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic reg_op(input cpu_isa_pkg::alu_op_e op, input logic [4:0] rd, rj, rk);
        logic [16:0] opc;
        case (op)
            cpu_isa_pkg::ALU_SUB:  opc = cpu_isa_pkg::OPC_3R_SUB;
            cpu_isa_pkg::ALU_SLT:  opc = cpu_isa_pkg::OPC_3R_SLT;
            cpu_isa_pkg::ALU_SLTU: opc = cpu_isa_pkg::OPC_3R_SLTU;
            cpu_isa_pkg::ALU_AND:  opc = cpu_isa_pkg::OPC_3R_AND;
            cpu_isa_pkg::ALU_OR:   opc = cpu_isa_pkg::OPC_3R_OR;
            cpu_isa_pkg::ALU_NOR:  opc = cpu_isa_pkg::OPC_3R_NOR;
            cpu_isa_pkg::ALU_XOR:  opc = cpu_isa_pkg::OPC_3R_XOR;
            cpu_isa_pkg::ALU_SLL:  opc = cpu_isa_pkg::OPC_3R_SLL;
            cpu_isa_pkg::ALU_SRL:  opc = cpu_isa_pkg::OPC_3R_SRL;
            cpu_isa_pkg::ALU_SRA:  opc = cpu_isa_pkg::OPC_3R_SRA;
            default:               opc = cpu_isa_pkg::OPC_3R_ADD;
        endcase
        issue({opc, rk, rj, rd}, rd != 5'd0, rd, ref_alu(op, model[rj], model[rk]));
    endtask

    task automatic imm_op(input cpu_isa_pkg::alu_op_e op, input logic [4:0] rd, rj,
                          input logic [11:0] imm);
        logic [9:0]   opc;
        logic [31:0]  b;
        b = {20'h0, imm};                                   // Logical ops zero-extend
        case (op)
            cpu_isa_pkg::ALU_ADD: begin
                opc = cpu_isa_pkg::OPC_2RI12_ADDI;
                b   = {{20{imm[11]}}, imm};
            end
            cpu_isa_pkg::ALU_AND: opc = cpu_isa_pkg::OPC_2RI12_ANDI;
            cpu_isa_pkg::ALU_OR:  opc = cpu_isa_pkg::OPC_2RI12_ORI;
            default:              opc = cpu_isa_pkg::OPC_2RI12_XORI;
        endcase
        issue({opc, imm, rj, rd}, rd != 5'd0, rd, ref_alu(op, model[rj], b));
    endtask

    task automatic upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        issue({cpu_isa_pkg::OPC_LU12I, imm, rd}, rd != 5'd0, rd, {imm, 12'h000});
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        upper_imm(rd, value[31:12]);
        imm_op(cpu_isa_pkg::ALU_OR, rd, rd, value[11:0]);
    endtask

    task automatic gap(input int n);
        repeat (n) begin
            @(posedge clk);
            i_inst_valid <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = err_count;
    endtask

    task automatic end_test;
        gap(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        test_count++;
        $display("%s finished with %0d error(s)", cur_test, err_count - test_errs);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic after_reset;
        start_test("reset");
        gap(5);                                             // Trace must stay quiet here
        reg_op(cpu_isa_pkg::ALU_ADD, 1, 0, 0);
        end_test;
    endtask

    task automatic three_reg_ops;
        logic [31:0] v;
        logic [4:0]  rj;
        logic [4:0]  rk;
        start_test("three_reg");
        for (int r = 1; r <= 8; r++) begin
            v = $random(seed);
            if (r == 1) v[31] = 1'b1;                       // Signed and unsigned order differ
            if (r == 2) v[31] = 1'b0;
            load_reg(r, v);
        end
        for (int i = 0; i <= 10; i++) begin
            for (int p = 0; p < 3; p++) begin
                rj = (p == 0) ? 5'd1 : (p == 1) ? 5'd2 : 5'(3 + i % 5);
                rk = (p == 0) ? 5'd2 : (p == 1) ? 5'd1 : 5'(4 + i % 4);
                reg_op(cpu_isa_pkg::alu_op_e'(i), 5'(10 + (3 * i + p) % 16), rj, rk);
            end
        end
        end_test;
    endtask

    task automatic immediate_ops;
        logic [11:0] imm;
        start_test("immediate");
        imm_op(cpu_isa_pkg::ALU_ADD, 11, 1, 12'hfff);
        imm_op(cpu_isa_pkg::ALU_ADD, 12, 2, 12'h800);
        imm_op(cpu_isa_pkg::ALU_AND, 13, 1, 12'h8f0);
        imm_op(cpu_isa_pkg::ALU_OR,  14, 2, 12'hfff);
        imm_op(cpu_isa_pkg::ALU_XOR, 15, 1, 12'h800);
        upper_imm(11, 20'h80001);
        upper_imm(12, 20'hfffff);
        for (int i = 0; i < 4; i++) begin
            imm = $random(seed);
            imm[11] = 1'b1;
            imm_op(cpu_isa_pkg::ALU_ADD, 11, 3, imm);
            imm_op(cpu_isa_pkg::ALU_AND, 12, 3, imm);
            imm_op(cpu_isa_pkg::ALU_OR,  13, 4, imm);
            imm_op(cpu_isa_pkg::ALU_XOR, 14, 4, imm);
        end
        end_test;
    endtask

    task automatic forwarding_chains;
        logic [11:0] imm;
        start_test("forwarding");
        load_reg(31, $random(seed));
        for (int i = 0; i < 4; i++) begin
            imm = $random(seed);
            imm_op(cpu_isa_pkg::ALU_ADD, 31, 31, imm);      // Same dest in execute and writeback
        end
        reg_op(cpu_isa_pkg::ALU_SLL, 30, 31, 1);
        for (int d = 1; d <= 3; d++) begin
            for (int side = 0; side < 2; side++) begin
                reg_op(cpu_isa_pkg::ALU_ADD, 26, 5'(1 + d), 5'(2 + side));
                for (int f = 1; f < d; f++) begin
                    reg_op(cpu_isa_pkg::ALU_XOR, 27, 3, 4);
                end
                if (side == 0) reg_op(cpu_isa_pkg::ALU_SUB, 29, 26, 5);
                else reg_op(cpu_isa_pkg::ALU_SLTU, 29, 5, 26);
            end
        end
        end_test;
    endtask

    task automatic r0_and_unknown;
        start_test("r0_unknown");
        imm_op(cpu_isa_pkg::ALU_ADD, 0, 1, 12'h005);
        reg_op(cpu_isa_pkg::ALU_OR, 9, 0, 2);
        reg_op(cpu_isa_pkg::ALU_ADD, 0, 3, 4);
        issue(32'h0000_0000, 1'b0, 5'd0, 32'h0);
        issue(32'hffff_ffff, 1'b0, 5'd0, 32'h0);
        reg_op(cpu_isa_pkg::ALU_SUB, 9, 9, 0);
        end_test;
    endtask

    task automatic random_gaps;
        logic [3:0] sel;
        start_test("gaps");
        for (int i = 0; i < 20; i++) begin
            gap($unsigned($random(seed)) % 4);
            sel = $unsigned($random(seed)) % 11;
            reg_op(cpu_isa_pkg::alu_op_e'(sel), 5'(9 + i % 8),
                   5'(1 + $unsigned($random(seed)) % 16), 5'(1 + $unsigned($random(seed)) % 16));
        end
        end_test;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Trace monitor
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!reset) begin
            if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
                head = exp_q.pop_front();
                compare("valid", 32'd1, o_wb_valid);
                compare("pc", head.pc, o_wb_pc);
                compare("we", head.we, o_wb_rf_we);
                if (head.we != 4'h0) begin
                    compare("wnum", head.wnum, o_wb_rf_wnum);
                    compare("wdata", head.wdata, o_wb_rf_wdata);
                end
            end else if (o_wb_valid !== 1'b0) begin
                err_count++;
                $display("Unexpected commit in %s: trace valid at pc %h with nothing due",
                         cur_test, o_wb_pc);
            end
        end
    end

    initial begin
        timeout_count = 0;
        while (timeout_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_count++;
        end
        $display("Run timed out after %0d cycles with %0d commits still awaited",
                 timeout_count, exp_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        i_inst_valid = 1'b0;
        i_pc         = 32'h0;
        i_inst       = 32'h0;
        next_pc      = 32'h1c00_0000;
        cycle        = 0;
        err_count    = 0;
        check_count  = 0;
        test_count   = 0;
        model[0]     = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        after_reset;
        three_reg_ops;
        immediate_ops;
        forwarding_chains;
        r0_and_unknown;
        random_gaps;
        gap(5);
        @(negedge clk);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, err_count, uut.u_sva.fail_count);
        if (err_count == 0 && uut.u_sva.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_pipe_pkg::decode_out_t  i_dec,
    input  cpu_pipe_pkg::exec_out_t    i_wb,
    output cpu_pipe_pkg::exec_out_t    o_exe
);

    logic [cpu_isa_pkg::XLEN-1:0]     op_a;
    logic [cpu_isa_pkg::XLEN-1:0]     rk_val;
    logic [cpu_isa_pkg::XLEN-1:0]     op_b;
    logic [cpu_isa_pkg::SHAMT_W-1:0]  shamt;
    logic                             lt_s;
    logic                             lt_u;
    logic [cpu_isa_pkg::XLEN-1:0]     alu_out;
    cpu_pipe_pkg::exec_out_t          exe_d;

    // Youngest producer wins, then writeback, then the decode-time read
    function automatic logic [cpu_isa_pkg::XLEN-1:0] fwd_src(
        input logic [cpu_isa_pkg::REG_ADDR_W-1:0] idx,
        input logic [cpu_isa_pkg::XLEN-1:0]       captured,
        input cpu_pipe_pkg::exec_out_t            exe,
        input cpu_pipe_pkg::exec_out_t            wb
    );
        logic [cpu_isa_pkg::XLEN-1:0] val;
        val = captured;
        if (exe.valid && exe.we && exe.dest == idx) begin
            val = exe.result;
        end else if (wb.valid && wb.we && wb.dest == idx) begin
            val = wb.result;
        end
        return val;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Operands
    // ~~~~~~~~~~~~~~~~~~~~
    assign op_a   = fwd_src(i_dec.rj, i_dec.src1, o_exe, i_wb);
    assign rk_val = fwd_src(i_dec.rk, i_dec.src2, o_exe, i_wb);
    assign op_b   = i_dec.use_imm ? i_dec.imm : rk_val;
    assign shamt  = op_b[cpu_isa_pkg::SHAMT_W-1:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (i_dec.op)
            cpu_isa_pkg::ALU_ADD:  alu_out = op_a + op_b;
            cpu_isa_pkg::ALU_SUB:  alu_out = op_a - op_b;
            cpu_isa_pkg::ALU_SLT:  alu_out = {{(cpu_isa_pkg::XLEN-1){1'b0}}, lt_s};
            cpu_isa_pkg::ALU_SLTU: alu_out = {{(cpu_isa_pkg::XLEN-1){1'b0}}, lt_u};
            cpu_isa_pkg::ALU_AND:  alu_out = op_a & op_b;
            cpu_isa_pkg::ALU_OR:   alu_out = op_a | op_b;
            cpu_isa_pkg::ALU_NOR:  alu_out = ~(op_a | op_b);
            cpu_isa_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            cpu_isa_pkg::ALU_SLL:  alu_out = op_a << shamt;
            cpu_isa_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            cpu_isa_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            cpu_isa_pkg::ALU_LUI:  alu_out = i_dec.imm;          // Already shifted at decode
            default:               alu_out = '0;
        endcase
    end

    always_comb begin
        exe_d.valid  = i_dec.valid;
        exe_d.pc     = i_dec.pc;
        exe_d.dest   = i_dec.dest;
        exe_d.we     = i_dec.we;
        exe_d.result = alu_out;
    end

    always_ff @(posedge clk) begin
        o_exe <= exe_d;
        if (reset) begin
            o_exe.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/cpu_core_top.sv
`timescale 1ns/1ns

module cpu_core_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                i_inst_valid,
    input  logic [cpu_isa_pkg::XLEN-1:0]        i_pc,
    input  logic [cpu_isa_pkg::INST_W-1:0]      i_inst,
    output logic                                o_wb_valid,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_wb_pc,
    output logic [3:0]                          o_wb_rf_we,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  o_wb_rf_wnum,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_wb_rf_wdata
);

    logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rf_raddr1;
    logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rf_raddr2;
    logic [cpu_isa_pkg::XLEN-1:0]        rf_rdata1;
    logic [cpu_isa_pkg::XLEN-1:0]        rf_rdata2;
    cpu_pipe_pkg::decode_out_t           dec;
    cpu_pipe_pkg::exec_out_t             exe;
    cpu_pipe_pkg::exec_out_t             wb;          // Fed back for forwarding

    inst_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .i_inst_valid (i_inst_valid),
        .i_pc         (i_pc),
        .i_inst       (i_inst),
        .i_rdata1     (rf_rdata1),
        .i_rdata2     (rf_rdata2),
        .o_raddr1     (rf_raddr1),
        .o_raddr2     (rf_raddr2),
        .o_dec        (dec)
    );

    alu_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .i_dec (dec),
        .i_wb  (wb),
        .o_exe (exe)
    );

    wb_result u_writeback (
        .clk           (clk),
        .reset         (reset),
        .i_exe         (exe),
        .i_raddr1      (rf_raddr1),
        .i_raddr2      (rf_raddr2),
        .o_rdata1      (rf_rdata1),
        .o_rdata2      (rf_rdata2),
        .o_wb          (wb),
        .o_wb_valid    (o_wb_valid),
        .o_wb_pc       (o_wb_pc),
        .o_wb_rf_we    (o_wb_rf_we),
        .o_wb_rf_wnum  (o_wb_rf_wnum),
        .o_wb_rf_wdata (o_wb_rf_wdata)
    );

endmodule

// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN       = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;              // Shift amount, low bits of operand 2

    // ~~~~~~~~~~~~~~~~~~~~
    // Field positions
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int SI12_LSB = 10;
    localparam int SI20_LSB = 5;
    localparam int SI12_W   = 12;
    localparam int SI20_W   = 20;

    // Major opcode widths, all anchored at bit 31
    localparam int OPC_3R_W     = 17;
    localparam int OPC_2RI12_W  = 10;
    localparam int OPC_LU12I_W  = 7;

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcode patterns
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [OPC_3R_W-1:0] OPC_3R_ADD  = 17'h00020;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SUB  = 17'h00022;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SLT  = 17'h00024;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SLTU = 17'h00025;
    localparam logic [OPC_3R_W-1:0] OPC_3R_NOR  = 17'h00028;
    localparam logic [OPC_3R_W-1:0] OPC_3R_AND  = 17'h00029;
    localparam logic [OPC_3R_W-1:0] OPC_3R_OR   = 17'h0002a;
    localparam logic [OPC_3R_W-1:0] OPC_3R_XOR  = 17'h0002b;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SLL  = 17'h0002e;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SRL  = 17'h0002f;
    localparam logic [OPC_3R_W-1:0] OPC_3R_SRA  = 17'h00030;

    localparam logic [OPC_2RI12_W-1:0] OPC_2RI12_ADDI = 10'h00a;  // Sign-extended imm
    localparam logic [OPC_2RI12_W-1:0] OPC_2RI12_ANDI = 10'h00d;  // Zero-extended imm
    localparam logic [OPC_2RI12_W-1:0] OPC_2RI12_ORI  = 10'h00e;
    localparam logic [OPC_2RI12_W-1:0] OPC_2RI12_XORI = 10'h00f;

    localparam logic [OPC_LU12I_W-1:0] OPC_LU12I = 7'h0a;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU operations
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_NOP
    } alu_op_e;

endpackage

// File: verilog/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode to execute
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                                valid;
        logic [cpu_isa_pkg::XLEN-1:0]        pc;
        cpu_isa_pkg::alu_op_e                op;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rj;      // Source indices, kept for forwarding
        logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rk;
        logic [cpu_isa_pkg::XLEN-1:0]        src1;    // Register file values seen at decode
        logic [cpu_isa_pkg::XLEN-1:0]        src2;
        logic                                use_imm;
        logic [cpu_isa_pkg::XLEN-1:0]        imm;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0]  dest;
        logic                                we;
    } decode_out_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Execute and writeback
    // ~~~~~~~~~~~~~~~~~~~~
    // Same record for both stages, both are fed back to execute
    typedef struct packed {
        logic                                valid;
        logic [cpu_isa_pkg::XLEN-1:0]        pc;
        logic [cpu_isa_pkg::REG_ADDR_W-1:0]  dest;
        logic                                we;
        logic [cpu_isa_pkg::XLEN-1:0]        result;
    } exec_out_t;

endpackage

// File: verilog/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                i_inst_valid,
    input  logic [cpu_isa_pkg::XLEN-1:0]        i_pc,
    input  logic [cpu_isa_pkg::INST_W-1:0]      i_inst,
    input  logic [cpu_isa_pkg::XLEN-1:0]        i_rdata1,
    input  logic [cpu_isa_pkg::XLEN-1:0]        i_rdata2,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  o_raddr1,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  o_raddr2,
    output cpu_pipe_pkg::decode_out_t           o_dec
);

    logic [cpu_isa_pkg::OPC_3R_W-1:0]     opc_3r;
    logic [cpu_isa_pkg::OPC_2RI12_W-1:0]  opc_2ri12;
    logic [cpu_isa_pkg::OPC_LU12I_W-1:0]  opc_lu12i;
    logic [cpu_isa_pkg::SI12_W-1:0]       si12;
    logic [cpu_isa_pkg::SI20_W-1:0]       si20;
    logic [cpu_isa_pkg::REG_ADDR_W-1:0]   rd;
    logic [cpu_isa_pkg::REG_ADDR_W-1:0]   rj;
    logic [cpu_isa_pkg::REG_ADDR_W-1:0]   rk;
    cpu_pipe_pkg::decode_out_t            dec_d;

    // ~~~~~~~~~~~~~~~~~~~~
    // Field extraction
    // ~~~~~~~~~~~~~~~~~~~~
    assign opc_3r    = i_inst[cpu_isa_pkg::INST_W-1 -: cpu_isa_pkg::OPC_3R_W];
    assign opc_2ri12 = i_inst[cpu_isa_pkg::INST_W-1 -: cpu_isa_pkg::OPC_2RI12_W];
    assign opc_lu12i = i_inst[cpu_isa_pkg::INST_W-1 -: cpu_isa_pkg::OPC_LU12I_W];
    assign si12      = i_inst[cpu_isa_pkg::SI12_LSB +: cpu_isa_pkg::SI12_W];
    assign si20      = i_inst[cpu_isa_pkg::SI20_LSB +: cpu_isa_pkg::SI20_W];
    assign rd        = i_inst[cpu_isa_pkg::RD_LSB +: cpu_isa_pkg::REG_ADDR_W];
    assign rj        = i_inst[cpu_isa_pkg::RJ_LSB +: cpu_isa_pkg::REG_ADDR_W];
    assign rk        = i_inst[cpu_isa_pkg::RK_LSB +: cpu_isa_pkg::REG_ADDR_W];

    assign o_raddr1 = rj;
    assign o_raddr2 = rk;                          // Don't care for immediate ops

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcode match
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dec_d         = '0;
        dec_d.valid   = i_inst_valid;
        dec_d.pc      = i_pc;
        dec_d.rj      = rj;
        dec_d.rk      = rk;
        dec_d.src1    = i_rdata1;
        dec_d.src2    = i_rdata2;
        dec_d.dest    = rd;
        dec_d.op      = cpu_isa_pkg::ALU_NOP;

        case (opc_3r)
            cpu_isa_pkg::OPC_3R_ADD:  dec_d.op = cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::OPC_3R_SUB:  dec_d.op = cpu_isa_pkg::ALU_SUB;
            cpu_isa_pkg::OPC_3R_SLT:  dec_d.op = cpu_isa_pkg::ALU_SLT;
            cpu_isa_pkg::OPC_3R_SLTU: dec_d.op = cpu_isa_pkg::ALU_SLTU;
            cpu_isa_pkg::OPC_3R_NOR:  dec_d.op = cpu_isa_pkg::ALU_NOR;
            cpu_isa_pkg::OPC_3R_AND:  dec_d.op = cpu_isa_pkg::ALU_AND;
            cpu_isa_pkg::OPC_3R_OR:   dec_d.op = cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::OPC_3R_XOR:  dec_d.op = cpu_isa_pkg::ALU_XOR;
            cpu_isa_pkg::OPC_3R_SLL:  dec_d.op = cpu_isa_pkg::ALU_SLL;
            cpu_isa_pkg::OPC_3R_SRL:  dec_d.op = cpu_isa_pkg::ALU_SRL;
            cpu_isa_pkg::OPC_3R_SRA:  dec_d.op = cpu_isa_pkg::ALU_SRA;
            default:                  dec_d.op = cpu_isa_pkg::ALU_NOP;
        endcase

        // Immediate forms, opcode spaces do not overlap the 3R ones
        if (opc_2ri12 == cpu_isa_pkg::OPC_2RI12_ADDI) begin
            dec_d.op      = cpu_isa_pkg::ALU_ADD;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {{(cpu_isa_pkg::XLEN-cpu_isa_pkg::SI12_W){si12[cpu_isa_pkg::SI12_W-1]}},
                             si12};
        end else if (opc_2ri12 == cpu_isa_pkg::OPC_2RI12_ANDI ||
                     opc_2ri12 == cpu_isa_pkg::OPC_2RI12_ORI ||
                     opc_2ri12 == cpu_isa_pkg::OPC_2RI12_XORI) begin
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {{(cpu_isa_pkg::XLEN-cpu_isa_pkg::SI12_W){1'b0}}, si12};
            if (opc_2ri12 == cpu_isa_pkg::OPC_2RI12_ANDI) begin
                dec_d.op = cpu_isa_pkg::ALU_AND;
            end else if (opc_2ri12 == cpu_isa_pkg::OPC_2RI12_ORI) begin
                dec_d.op = cpu_isa_pkg::ALU_OR;
            end else begin
                dec_d.op = cpu_isa_pkg::ALU_XOR;
            end
        end else if (opc_lu12i == cpu_isa_pkg::OPC_LU12I) begin
            dec_d.op      = cpu_isa_pkg::ALU_LUI;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {si20, {(cpu_isa_pkg::XLEN-cpu_isa_pkg::SI20_W){1'b0}}};
        end

        // r0 writes dropped here so forwarding never picks them up
        dec_d.we = (dec_d.op != cpu_isa_pkg::ALU_NOP) && (rd != '0);
    end

    always_ff @(posedge clk) begin
        o_dec <= dec_d;
        if (reset) begin
            o_dec.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/wb_result.sv
`timescale 1ns/1ns

module wb_result (
    input  logic                                clk,
    input  logic                                reset,
    input  cpu_pipe_pkg::exec_out_t             i_exe,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  i_raddr1,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  i_raddr2,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_rdata1,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_rdata2,
    output cpu_pipe_pkg::exec_out_t             o_wb,
    output logic                                o_wb_valid,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_wb_pc,
    output logic [3:0]                          o_wb_rf_we,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  o_wb_rf_wnum,
    output logic [cpu_isa_pkg::XLEN-1:0]        o_wb_rf_wdata
);

    logic [cpu_isa_pkg::XLEN-1:0]  regs [cpu_isa_pkg::NUM_REGS];
    logic                          rf_wr;

    // ~~~~~~~~~~~~~~~~~~~~
    // Writeback register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        o_wb <= i_exe;
        if (reset) begin
            o_wb.valid <= 1'b0;
        end
    end

    assign rf_wr = o_wb.valid && o_wb.we && (o_wb.dest != '0);

    // ~~~~~~~~~~~~~~~~~~~~
    // Register file
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rf_wr) begin
            regs[o_wb.dest] <= o_wb.result;
        end
    end

    // Same-cycle write is bypassed to the readers, r0 is hardwired
    always_comb begin
        if (i_raddr1 == '0) begin
            o_rdata1 = '0;
        end else if (rf_wr && o_wb.dest == i_raddr1) begin
            o_rdata1 = o_wb.result;
        end else begin
            o_rdata1 = regs[i_raddr1];
        end
    end

    always_comb begin
        if (i_raddr2 == '0) begin
            o_rdata2 = '0;
        end else if (rf_wr && o_wb.dest == i_raddr2) begin
            o_rdata2 = o_wb.result;
        end else begin
            o_rdata2 = regs[i_raddr2];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit trace
    // ~~~~~~~~~~~~~~~~~~~~
    assign o_wb_valid    = o_wb.valid;
    assign o_wb_pc       = o_wb.pc;
    assign o_wb_rf_we    = {4{rf_wr}};
    assign o_wb_rf_wnum  = o_wb.dest;
    assign o_wb_rf_wdata = o_wb.result;

endmodule
